//--- flist.f
verilog/fetch_pkg.sv
verilog/assoc_icache.sv
verilog/backing_mem.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit_top.sv
verif/fetch_unit_props.sv
verif/fetch_unit_tb.sv

//--- Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = fetch_unit_tb
FLIST   = flist.f
OBJ     = obj_dir
LOG     = sim.log
SIMARGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)
	./$(OBJ)/V$(TOP) $(SIMARGS) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

//--- verif/fetch_unit_tb.sv
// ============================================================
// Testbench for the instruction fetch unit
// Table-driven fetch, load and flush sequences checked against
// a memory model and a snapshot of what the cache may return
// ============================================================

`default_nettype none

module fetch_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum {OP_FETCH, OP_LOAD, OP_FLUSH} op_e;
	typedef enum {EXP_MISS, EXP_HIT, EXP_ANY} hit_e;

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic                         req;
	logic [fetch_pkg::W_ADDR-1:0] addr;
	logic                         resp_valid;
	logic [fetch_pkg::W_DATA-1:0] resp_data;
	logic                         resp_hit;
	logic                         busy;
	logic                         flush;
	logic                         load_en;
	logic [fetch_pkg::W_ADDR-1:0] load_addr;
	logic [fetch_pkg::W_DATA-1:0] load_data;

	// Stimulus table with one entry per row in each queue
	string                        row_name [$];
	op_e                          row_op   [$];
	logic [fetch_pkg::W_ADDR-1:0] row_addr [$];
	logic [fetch_pkg::W_DATA-1:0] row_data [$];
	hit_e                         row_hit  [$];

	// Current memory contents, and the contents as of the last flush
	// The cache is read-only, so a fetch can only return the latter
	logic [fetch_pkg::W_DATA-1:0] mem_model  [fetch_pkg::MEM_WORDS];
	logic [fetch_pkg::W_DATA-1:0] view_model [fetch_pkg::MEM_WORDS];
	int                           errors;

	fetch_unit_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.addr       (addr),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.resp_hit   (resp_hit),
		.busy       (busy),
		.flush      (flush),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data)
	);

	always #5 clk = ~clk;

	// ============================================================
	// Helpers
	// ============================================================

	// Memory word index sits above the two byte bits
	function automatic int word_index(input logic [fetch_pkg::W_ADDR-1:0] a);
		return int'(a[fetch_pkg::W_MEM_IDX+1:2]);
	endfunction

	task automatic add_row(input string n, input op_e op, input logic [15:0] a,
			input logic [31:0] d, input hit_e h);
		row_name.push_back(n);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_data.push_back(d);
		row_hit.push_back(h);
	endtask

	task automatic build_table();
		add_row("cold_a", OP_FETCH, 16'h0040, '0, EXP_MISS);
		add_row("warm_a", OP_FETCH, 16'h0040, '0, EXP_HIT);
		add_row("cold_b", OP_FETCH, 16'h0100, '0, EXP_MISS);
		// Same word with the byte bits set must find the same entry
		add_row("warm_b_byte3", OP_FETCH, 16'h0103, '0, EXP_HIT);
		// Ten new words overflow the eight entries
		for (int i = 0; i < 10; i++) begin
			add_row($sformatf("sweep_cold_%0d", i), OP_FETCH, 16'h0200 + 16'(i * 4), '0, EXP_MISS);
		end
		for (int i = 0; i < 10; i++) begin
			add_row($sformatf("sweep_again_%0d", i), OP_FETCH, 16'h0200 + 16'(i * 4), '0, EXP_ANY);
		end
		add_row("cold_c", OP_FETCH, 16'h0300, '0, EXP_MISS);
		add_row("warm_c", OP_FETCH, 16'h0300, '0, EXP_HIT);
		add_row("load_c", OP_LOAD, 16'h0300, $urandom, EXP_ANY);
		add_row("stale_c", OP_FETCH, 16'h0300, '0, EXP_HIT);
		add_row("flush_1", OP_FLUSH, '0, '0, EXP_ANY);
		add_row("fresh_c", OP_FETCH, 16'h0300, '0, EXP_MISS);
		add_row("load_d", OP_LOAD, 16'h03f0, $urandom, EXP_ANY);
		add_row("flush_2", OP_FLUSH, '0, '0, EXP_ANY);
		add_row("fresh_d", OP_FETCH, 16'h03f0, '0, EXP_MISS);
		add_row("cold_a_again", OP_FETCH, 16'h0040, '0, EXP_MISS);
		add_row("warm_a_again", OP_FETCH, 16'h0040, '0, EXP_HIT);
	endtask

	// All tasks below start and end on a falling edge
	task automatic load_word(input logic [15:0] a, input logic [31:0] d);
		load_en   = 1'b1;
		load_addr = a;
		load_data = d;
		mem_model[word_index(a)] = d;
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic flush_cache();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
			view_model[i] = mem_model[i];
		end
	endtask

	// Returns on the falling edge inside the response cycle, so a fetch
	// that follows is issued while the previous response is still up
	task automatic fetch_and_check(input int r);
		logic [fetch_pkg::W_DATA-1:0] exp_data;
		int                           waited;
		exp_data = view_model[word_index(row_addr[r])];
		waited   = 0;
		req      = 1'b1;
		addr     = row_addr[r];
		@(negedge clk);
		req = 1'b0;
		while (!resp_valid && waited < fetch_pkg::MEM_LATENCY + 2) begin
			// A miss holds busy from the cycle after the request until its response
			assert (busy) else begin
				errors++;
				$display("MISMATCH %s busy expected 1 actual %0d", row_name[r], busy);
			end
			@(negedge clk);
			waited++;
		end
		assert (resp_valid) else begin
			errors++;
			$display("fetch %s got no response within %0d cycles", row_name[r], waited + 1);
		end
		if (resp_valid) begin
			assert (resp_data == exp_data) else begin
				errors++;
				$display("MISMATCH %s data expected %08h actual %08h",
					row_name[r], exp_data, resp_data);
			end
			if (row_hit[r] != EXP_ANY) begin
				assert (resp_hit == (row_hit[r] == EXP_HIT)) else begin
					errors++;
					$display("MISMATCH %s hit expected %0d actual %0d",
						row_name[r], row_hit[r] == EXP_HIT, resp_hit);
				end
			end
		end
	endtask

	task automatic watchdog(input int limit_ns);
		#(limit_ns);
		$display("watchdog expired after %0d ns, the run did not finish", limit_ns);
		$display("*** FAILED ***");
		$finish;
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		int limit_ns;
		int prop_fails;
		rst_n     = 1'b0;
		req       = 1'b0;
		addr      = '0;
		flush     = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		errors    = 0;
		void'($urandom(32'he97b60c3));
		build_table();
		limit_ns = (row_name.size() + fetch_pkg::MEM_WORDS) * (fetch_pkg::MEM_LATENCY + 4) * 10;
		fork
			watchdog(limit_ns);
		join_none

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Fill the whole memory while the cache is still empty
		for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
			load_word(16'(i * 4), $urandom);
		end
		for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
			view_model[i] = mem_model[i];
		end

		for (int r = 0; r < row_name.size(); r++) begin
			case (row_op[r])
				OP_FETCH: fetch_and_check(r);
				OP_LOAD:  load_word(row_addr[r], row_data[r]);
				OP_FLUSH: flush_cache();
				default:  ;
			endcase
		end
		repeat (2) @(negedge clk);

		prop_fails = int'(DUT.u_props.fail_count);
		$display("check errors %0d, property failures %0d", errors, prop_fails);
		if (errors == 0 && prop_fails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/fetch_unit_props.sv
// ============================================================
// Timing rules of the fetch unit top level
// Bound into the top level, watches requests and responses
// ============================================================

`default_nettype none

module fetch_unit_props (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic lookup_hit,
	input logic busy,
	input logic resp_valid,
	input logic resp_hit
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench at the end of the run
	int unsigned fail_count = 0;

	// The controller ignores a request while a refill is in flight
	no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> !busy)
		else begin
			fail_count++;
			$error("request issued while busy");
		end

	hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		req && !busy && lookup_hit |=> resp_valid && resp_hit)
		else begin
			fail_count++;
			$error("hit response not one cycle after the request");
		end

	// Memory latency plus the response cycle
	miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
		req && !busy && !lookup_hit |-> ##(fetch_pkg::MEM_LATENCY + 1) resp_valid && !resp_hit)
		else begin
			fail_count++;
			$error("miss response not at the expected cycle");
		end

	resp_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> !busy)
		else begin
			fail_count++;
			$error("busy high during a response");
		end

endmodule

bind fetch_unit_top fetch_unit_props u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.req        (req),
	.lookup_hit (lookup_hit),
	.busy       (busy),
	.resp_valid (resp_valid),
	.resp_hit   (resp_hit)
);

`default_nettype wire

//--- verilog/fetch_unit_top.sv
// ============================================================
// Instruction fetch unit
// Controller, associative cache and backing memory
// ============================================================

`default_nettype none

module fetch_unit_top (
	input  logic                         clk,
	input  logic                         rst_n,

	input  logic                         req,
	input  logic [fetch_pkg::W_ADDR-1:0] addr,
	output logic                         resp_valid,
	output logic [fetch_pkg::W_DATA-1:0] resp_data,
	output logic                         resp_hit,
	output logic                         busy,

	input  logic                         flush,

	input  logic                         load_en,
	input  logic [fetch_pkg::W_ADDR-1:0] load_addr,
	input  logic [fetch_pkg::W_DATA-1:0] load_data
);

	// Controller to cache
	logic [fetch_pkg::W_ADDR-1:0] lookup_addr;
	logic                         lookup_hit;
	logic [fetch_pkg::W_DATA-1:0] lookup_data;
	logic                         fill_en;
	logic [fetch_pkg::W_ADDR-1:0] fill_addr;
	logic [fetch_pkg::W_DATA-1:0] fill_data;

	// Controller to memory
	logic                         mem_rd;
	logic [fetch_pkg::W_ADDR-1:0] mem_addr;
	logic                         mem_valid;
	logic [fetch_pkg::W_DATA-1:0] mem_data;

	fetch_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.addr        (addr),
		.resp_valid  (resp_valid),
		.resp_data   (resp_data),
		.resp_hit    (resp_hit),
		.busy        (busy),
		.lookup_addr (lookup_addr),
		.lookup_hit  (lookup_hit),
		.lookup_data (lookup_data),
		.fill_en     (fill_en),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.mem_rd      (mem_rd),
		.mem_addr    (mem_addr),
		.mem_valid   (mem_valid),
		.mem_data    (mem_data)
	);

	// Flush goes straight to the cache, the controller never sees it
	assoc_icache u_cache (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_addr (lookup_addr),
		.lookup_hit  (lookup_hit),
		.lookup_data (lookup_data),
		.fill_en     (fill_en),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.flush       (flush)
	);

	backing_mem u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.mem_rd    (mem_rd),
		.mem_addr  (mem_addr),
		.mem_valid (mem_valid),
		.mem_data  (mem_data)
	);

endmodule

`default_nettype wire

//--- verilog/fetch_ctrl.sv
// ============================================================
// Fetch controller
// Serves hits from the cache and sequences refills on a miss
// ============================================================

`default_nettype none

module fetch_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,

	// Fetch stage side
	input  logic                         req,
	input  logic [fetch_pkg::W_ADDR-1:0] addr,
	output logic                         resp_valid,
	output logic [fetch_pkg::W_DATA-1:0] resp_data,
	output logic                         resp_hit,
	output logic                         busy,

	// Cache side
	output logic [fetch_pkg::W_ADDR-1:0] lookup_addr,
	input  logic                         lookup_hit,
	input  logic [fetch_pkg::W_DATA-1:0] lookup_data,
	output logic                         fill_en,
	output logic [fetch_pkg::W_ADDR-1:0] fill_addr,
	output logic [fetch_pkg::W_DATA-1:0] fill_data,

	// Backing memory side
	output logic                         mem_rd,
	output logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	input  logic                         mem_valid,
	input  logic [fetch_pkg::W_DATA-1:0] mem_data
);

	fetch_pkg::fetch_state_e      state;
	fetch_pkg::fetch_state_e      state_nxt;

	logic                         accept;
	logic                         miss_req;
	logic                         hit_pend;
	logic [fetch_pkg::W_ADDR-1:0] miss_addr;
	logic [fetch_pkg::W_DATA-1:0] miss_data;

	// ============================================================
	// Request decode
	// ============================================================

	// Requests are taken in IDLE and in the response cycle of a miss
	assign accept   = req && (state != fetch_pkg::MISS_WAIT);
	assign miss_req = accept && !lookup_hit;

	// Tag lookup sees the address in the same cycle as the strobe
	assign lookup_addr = addr;

	// The memory read goes out in the request cycle, no extra stage
	assign mem_rd   = miss_req;
	assign mem_addr = addr;

	// Refill is written into the cache as the word arrives
	assign fill_en   = (state == fetch_pkg::MISS_WAIT) && mem_valid;
	assign fill_addr = miss_addr;
	assign fill_data = mem_data;

	// ============================================================
	// State machine
	// ============================================================

	always_comb begin
		state_nxt = state;
		case (state)
			fetch_pkg::IDLE:      if (miss_req) state_nxt = fetch_pkg::MISS_WAIT;
			fetch_pkg::MISS_WAIT: if (mem_valid) state_nxt = fetch_pkg::RESPOND;
			// Back to back miss is possible straight out of RESPOND
			fetch_pkg::RESPOND:   state_nxt = miss_req ? fetch_pkg::MISS_WAIT : fetch_pkg::IDLE;
			default:              state_nxt = fetch_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= fetch_pkg::IDLE;
			hit_pend <= 1'b0;
		end else begin
			state    <= state_nxt;
			// Data for a hit is registered by the cache on this same edge
			hit_pend <= accept && lookup_hit;
		end
	end

	// Miss bookkeeping
	always_ff @(posedge clk) begin
		if (miss_req) begin
			miss_addr <= addr;
		end
		if (fill_en) begin
			miss_data <= mem_data;
		end
	end

	// ============================================================
	// Response
	// ============================================================

	// A hit response and RESPOND never overlap, since no request is
	// accepted while waiting on memory
	assign resp_valid = hit_pend || (state == fetch_pkg::RESPOND);
	assign resp_hit   = hit_pend;
	assign resp_data  = hit_pend ? lookup_data : miss_data;
	assign busy       = (state == fetch_pkg::MISS_WAIT);

endmodule

`default_nettype wire

//--- verilog/backing_mem.sv
// ============================================================
// Backing word memory for the fetch subsystem
// Filled through a load port, read with a fixed latency
// ============================================================

`default_nettype none

module backing_mem (
	input  logic                         clk,
	input  logic                         rst_n,

	input  logic                         load_en,
	input  logic [fetch_pkg::W_ADDR-1:0] load_addr,
	input  logic [fetch_pkg::W_DATA-1:0] load_data,

	input  logic                         mem_rd,
	input  logic [fetch_pkg::W_ADDR-1:0] mem_addr,
	output logic                         mem_valid,
	output logic [fetch_pkg::W_DATA-1:0] mem_data
);

	logic [fetch_pkg::W_DATA-1:0]      mem [fetch_pkg::MEM_WORDS];

	// Word index is taken above the two byte bits
	logic [fetch_pkg::W_MEM_IDX-1:0]   load_idx;
	logic [fetch_pkg::W_MEM_IDX-1:0]   rd_idx;

	// Read pipeline, stage 0 is loaded at the strobe
	logic [fetch_pkg::MEM_LATENCY-1:0] rd_vld_q;
	logic [fetch_pkg::W_DATA-1:0]      rd_data_q [fetch_pkg::MEM_LATENCY];

	assign load_idx = load_addr[fetch_pkg::W_MEM_IDX+1:2];
	assign rd_idx   = mem_addr[fetch_pkg::W_MEM_IDX+1:2];

	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_idx] <= load_data;
		end
	end

	// The word is captured at the strobe. A later load cannot change
	// a read that is already travelling down the pipe
	always_ff @(posedge clk) begin
		rd_data_q[0] <= mem[rd_idx];
		for (int i = 1; i < fetch_pkg::MEM_LATENCY; i++) begin
			rd_data_q[i] <= rd_data_q[i-1];
		end
	end

	// Valid bits shift alongside the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_vld_q <= '0;
		end else begin
			rd_vld_q <= {rd_vld_q[fetch_pkg::MEM_LATENCY-2:0], mem_rd};
		end
	end

	assign mem_valid = rd_vld_q[fetch_pkg::MEM_LATENCY-1];
	assign mem_data  = rd_data_q[fetch_pkg::MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/assoc_icache.sv
// ============================================================
// Fully associative read-only instruction cache
// Hit flag is combinational and data follows one edge later
// Refills go to a pseudorandom victim and a flush clears all
// ============================================================

`default_nettype none

module assoc_icache (
	input  logic                         clk,
	input  logic                         rst_n,

	input  logic [fetch_pkg::W_ADDR-1:0] lookup_addr,
	output logic                         lookup_hit,
	output logic [fetch_pkg::W_DATA-1:0] lookup_data,

	input  logic                         fill_en,
	input  logic [fetch_pkg::W_ADDR-1:0] fill_addr,
	input  logic [fetch_pkg::W_DATA-1:0] fill_data,

	input  logic                         flush
);

	// Entry storage. Only the valid bits carry control meaning
	logic [fetch_pkg::W_TAG-1:0]     tag_mem  [fetch_pkg::N_ENTRIES];
	logic [fetch_pkg::W_DATA-1:0]    data_mem [fetch_pkg::N_ENTRIES];
	logic [fetch_pkg::N_ENTRIES-1:0] valid;

	logic [fetch_pkg::W_TAG-1:0]     lookup_tag;
	logic [fetch_pkg::W_TAG-1:0]     fill_tag;

	// Drop the byte offset, the cache works on whole words only
	assign lookup_tag = lookup_addr[fetch_pkg::W_ADDR-1 -: fetch_pkg::W_TAG];
	assign fill_tag   = fill_addr[fetch_pkg::W_ADDR-1 -: fetch_pkg::W_TAG];

	// ============================================================
	// Eviction selector
	// ============================================================

	// 16-bit Fibonacci LFSR, taps 16 14 13 4
	logic [15:0]                 evict_lfsr;
	logic                        lfsr_fb;
	logic [fetch_pkg::W_IDX-1:0] victim_idx;

	assign lfsr_fb = evict_lfsr[15] ^ evict_lfsr[13] ^ evict_lfsr[12] ^ evict_lfsr[3];

	// The low bits are good enough to spread refills over the entries
	assign victim_idx = evict_lfsr[fetch_pkg::W_IDX-1:0];

	// Free running, so the victim depends on when the miss lands
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			evict_lfsr <= fetch_pkg::LFSR_SEED;
		end else begin
			evict_lfsr <= {evict_lfsr[14:0], lfsr_fb};
		end
	end

	// ============================================================
	// Parallel tag match and index encoder
	// ============================================================

	logic [fetch_pkg::N_ENTRIES-1:0] match;
	logic [fetch_pkg::W_IDX-1:0]     match_idx;

	// Every entry compares its tag at once. An invalid entry never matches
	always_comb begin
		for (int i = 0; i < fetch_pkg::N_ENTRIES; i++) begin
			match[i] = valid[i] && (tag_mem[i] == lookup_tag);
		end
	end

	assign lookup_hit = |match;

	// OR-accumulating encoder, a flat sum of products
	// Only correct for a one-hot vector, which holds since a fill
	// always follows a miss on the same tag
	always_comb begin
		match_idx = '0;
		for (int i = 0; i < fetch_pkg::N_ENTRIES; i++) begin
			if (match[i]) begin
				match_idx = match_idx | i[fetch_pkg::W_IDX-1:0];
			end
		end
	end

	// ============================================================
	// Read data register
	// ============================================================

	// Loaded every cycle whether or not there is a hit
	// The controller decides whether the word is used
	always_ff @(posedge clk) begin
		lookup_data <= data_mem[match_idx];
	end

	// ============================================================
	// Fill and flush
	// ============================================================

	// Tag and data of the victim are overwritten on a fill
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_mem[victim_idx]  <= fill_tag;
			data_mem[victim_idx] <= fill_data;
		end
	end

	// Flush takes priority, so a refill racing it is discarded
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (flush) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[victim_idx] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
// ============================================================
// Fetch subsystem shared definitions
// Sizes, memory latency, eviction seed and controller states
// ============================================================

`default_nettype none

package fetch_pkg;

	// ============================================================
	// Address and data geometry
	// ============================================================

	// Byte address presented by the fetch stage
	localparam int W_ADDR = 16;
	localparam int W_DATA = 32;
	// Tag is the word address, the two byte bits are dropped
	localparam int W_TAG = W_ADDR - 2;

	// Cache has a small number of fully associative entries
	localparam int N_ENTRIES = 8;
	localparam int W_IDX = $clog2(N_ENTRIES);

	// Backing memory is indexed by address bits 9 down to 2
	localparam int MEM_WORDS = 256;
	localparam int W_MEM_IDX = $clog2(MEM_WORDS);

	// Cycles from a read strobe to the matching data valid pulse
	localparam int MEM_LATENCY = 3;

	// Any nonzero value works here. An all-zero LFSR would stick
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	// ============================================================
	// Fetch controller states
	// ============================================================

	typedef enum logic [1:0] {
		IDLE,
		MISS_WAIT,
		RESPOND
	} fetch_state_e;

endpackage

`default_nettype wire
